//--- tests/core_trace.txt
# kind addr data, all hex: W write, R read expecting data, E write expecting pslverr.
# Register n reads at 100 + 4n; status holds count in bits 2:0 and busy in bit 8.
# Idle after reset.
R 004 00000000
R 008 00000001
# I-type and R-type results.
W 000 34018001  # ori   r1 = r0 | 0x8001
W 000 2402ffff  # addiu r2 = r0 + -1
W 000 30438f0f  # andi  r3 = r2 & 0x8f0f
W 000 3c04a5c3  # lui   r4 = 0xa5c3 << 16
W 000 00242821  # addu  r5 = r1 + r4
W 000 00223023  # subu  r6 = r1 - r2
W 000 00643825  # or    r7 = r3 | r4
W 000 00a34024  # and   r8 = r5 & r3
W 000 24200005  # addiu r0 = r1 + 5, discarded
R 104 00008001
R 108 ffffffff
R 10c 00008f0f
R 110 a5c30000
R 114 a5c38001
R 118 00008002
R 11c a5c38f0f
R 120 00008001
R 100 00000000
# Dependent chain.
W 000 24090007  # addiu r9  = r0 + 7
W 000 01295021  # addu  r10 = r9 + r9
W 000 01495823  # subu  r11 = r10 - r9
R 124 00000007
R 128 0000000e
R 12c 00000007
# Halted core, queue fills and the fifth push is refused.
W 008 00000000
W 000 240c0001  # addiu r12 = r0 + 1
W 000 258c0001  # addiu r12 = r12 + 1
W 000 258c0001
W 000 258c0001
R 004 00000104
E 000 258c0001
R 008 00000000
W 008 00000001
R 130 00000004
# Unknown opcode and refused writes.
W 000 fc2d8400  # op 0x3f, r13 = r1 | sext(0x8400)
R 134 ffff8401
E 004 00000000
E 104 00000001
E 00c 00000000
E 800 00000000

//--- tb.f
source/isa_pkg.sv
source/core_pkg.sv
source/dispatch_decoder.sv
source/issue_queue.sv
source/execute_unit.sv
source/core_top.sv
tests/core_tb.sv

//--- Makefile
SOURCES := $(shell cat tb.f)

.PHONY: all run clean

all: obj_dir/Vcore_tb

obj_dir/Vcore_tb: tb.f $(SOURCES) tests/core_trace.txt
	verilator --binary --timing -Wno-fatal --top-module core_tb -f tb.f

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- tests/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb;

        localparam int    CLK_PERIOD      = 100;
        localparam int    RESET_CYCLES    = 5;
        localparam int    CYCLES_PER_LINE = 40;
        localparam int    APB_WAIT_LIMIT  = 16;
        localparam int    POLL_LIMIT      = 64;
        localparam int    BUSY_BIT        = 8;
        localparam string TRACE_FILE      = "tests/core_trace.txt";

        logic        pclk;
        logic        rst_n;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
        int          line_count = 0;

        core_top DUT (
                .pclk_i    (pclk),
                .rst_n_i   (rst_n),
                .psel_i    (psel),
                .penable_i (penable),
                .pwrite_i  (pwrite),
                .paddr_i   (paddr),
                .pwdata_i  (pwdata),
                .prdata_o  (prdata),
                .pready_o  (pready),
                .pslverr_o (pslverr)
        );

        initial begin
                pclk = 1'b0;
                forever #(CLK_PERIOD / 2) pclk = ~pclk;
        end

        task automatic stop_with_failure();
                $display("*** FAILED ***");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic check_word(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("Mismatch at %0t: %s expected %h, got %h",
                                 $time, name, expected, actual);
                        stop_with_failure();
                end
        endtask

        task automatic check_status(input logic [core_pkg::QUEUE_AW:0] exp_count,
                                    input logic exp_busy, input logic [31:0] word);
                logic [core_pkg::QUEUE_AW:0] count;
                logic                        busy;
                count = word[core_pkg::QUEUE_AW:0];
                busy  = word[BUSY_BIT];
                if (count !== exp_count || busy !== exp_busy) begin
                        $display("Mismatch at %0t: status count/busy expected %0d/%b, got %0d/%b",
                                 $time, exp_count, exp_busy, count, busy);
                        stop_with_failure();
                end
        endtask

        task automatic check_err(input logic [11:0] addr, input logic expected,
                                 input logic actual);
                if (actual !== expected) begin
                        $display("Mismatch at %0t: pslverr at address %h expected %b, got %b",
                                 $time, addr, expected, actual);
                        stop_with_failure();
                end
        endtask

        // Setup edge, access edge, sample at the falling edge in between.
        task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                    input logic [31:0] wdata, output logic [31:0] rdata,
                                    output logic err);
                int waited;
                waited = 0;
                @(posedge pclk);
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= write;
                paddr   <= addr;
                pwdata  <= wdata;
                @(posedge pclk);
                penable <= 1'b1;
                @(negedge pclk);
                while (pready !== 1'b1) begin
                        if (waited == APB_WAIT_LIMIT) begin
                                $display("APB transfer to address %h never completed", addr);
                                stop_with_failure();
                        end
                        waited++;
                        @(negedge pclk);
                end
                rdata = prdata;
                err   = pslverr;
                @(posedge pclk);
                psel    <= 1'b0;
                penable <= 1'b0;
                pwrite  <= 1'b0;
        endtask

        task automatic wait_until_idle();
                logic [31:0] word;
                logic        err;
                int          polls;
                polls = 0;
                apb_transfer(1'b0, core_pkg::ADDR_STATUS, 32'b0, word, err);
                while (word[BUSY_BIT] !== 1'b0) begin
                        if (polls == POLL_LIMIT) begin
                                $display("The core stayed busy after %0d status polls", polls);
                                stop_with_failure();
                        end
                        polls++;
                        apb_transfer(1'b0, core_pkg::ADDR_STATUS, 32'b0, word, err);
                end
                check_err(core_pkg::ADDR_STATUS, 1'b0, err);
        endtask

        function automatic string reg_name(input logic [11:0] addr);
                if (addr == core_pkg::ADDR_CTRL)
                        return "ctrl";
                return $sformatf("r%0d", (addr - core_pkg::ADDR_REG_BASE) >> 2);
        endfunction

        // Word addresses of the APB map, registers included.
        function automatic logic addr_is_mapped(input logic [11:0] addr);
                int reg_end;
                reg_end = core_pkg::ADDR_REG_BASE + 4 * core_pkg::REG_COUNT;
                if (addr[1:0] != 2'b00)
                        return 1'b0;
                if (addr == core_pkg::ADDR_INST || addr == core_pkg::ADDR_STATUS ||
                    addr == core_pkg::ADDR_CTRL)
                        return 1'b1;
                return addr >= core_pkg::ADDR_REG_BASE && addr < reg_end;
        endfunction

        // Every register is zero out of reset.
        task automatic sweep_reset_registers();
                logic [11:0] addr;
                logic [31:0] rdata;
                logic        err;
                for (int n = 0; n < core_pkg::REG_COUNT; n++) begin
                        addr = core_pkg::ADDR_REG_BASE + 12'(4 * n);
                        apb_transfer(1'b0, addr, 32'b0, rdata, err);
                        check_err(addr, 1'b0, err);
                        check_word(reg_name(addr), 32'b0, rdata);
                end
        endtask

        task automatic replay_entry(input logic [7:0] kind, input logic [11:0] addr,
                                    input logic [31:0] data);
                logic [31:0] rdata;
                logic        err;
                case (kind)
                        "W": begin
                                apb_transfer(1'b1, addr, data, rdata, err);
                                check_err(addr, 1'b0, err);
                        end
                        "E": begin
                                apb_transfer(1'b1, addr, data, rdata, err);
                                check_err(addr, 1'b1, err);
                                if (!addr_is_mapped(addr)) begin
                                        // A hole refuses reads too.
                                        apb_transfer(1'b0, addr, 32'b0, rdata, err);
                                        check_err(addr, 1'b1, err);
                                end
                        end
                        "R": begin
                                if (addr >= core_pkg::ADDR_REG_BASE)
                                        wait_until_idle(); // Let queued work retire.
                                apb_transfer(1'b0, addr, 32'b0, rdata, err);
                                check_err(addr, 1'b0, err);
                                if (addr == core_pkg::ADDR_STATUS)
                                        check_status(data[core_pkg::QUEUE_AW:0],
                                                     data[BUSY_BIT], rdata);
                                else
                                        check_word(reg_name(addr), data, rdata);
                        end
                        default: begin
                                $display("Trace holds an unknown entry kind '%c'", kind);
                                stop_with_failure();
                        end
                endcase
        endtask

        task automatic count_trace_lines(output int lines);
                int               fd;
                logic [8*256-1:0] text;
                lines = 0;
                fd = $fopen(TRACE_FILE, "r");
                if (fd == 0) begin
                        $display("Cannot open the trace file %s", TRACE_FILE);
                        stop_with_failure();
                end
                while ($fgets(text, fd) != 0)
                        lines++;
                $fclose(fd);
        endtask

        task automatic run_trace();
                int               fd;
                int               code;
                logic [7:0]       kind;
                logic [11:0]      addr;
                logic [31:0]      data;
                logic [8*256-1:0] rest;
                fd = $fopen(TRACE_FILE, "r");
                code = $fscanf(fd, " %c", kind);
                while (code == 1) begin
                        if (kind == "#") begin
                                code = $fgets(rest, fd);
                        end else begin
                                code = $fscanf(fd, "%h %h", addr, data);
                                if (code != 2) begin
                                        $display("Trace line after entry kind '%c' is malformed",
                                                 kind);
                                        stop_with_failure();
                                end
                                code = $fgets(rest, fd); // Trailing comment.
                                replay_entry(kind, addr, data);
                        end
                        code = $fscanf(fd, " %c", kind);
                end
                $fclose(fd);
        endtask

        initial begin
                wait (line_count > 0);
                repeat ((line_count + core_pkg::REG_COUNT) * CYCLES_PER_LINE + RESET_CYCLES)
                        @(posedge pclk);
                $display("Timeout: the run did not finish in time for %0d trace lines",
                         line_count);
                stop_with_failure();
        end

        initial begin
                rst_n   <= 1'b0;
                psel    <= 1'b0;
                penable <= 1'b0;
                pwrite  <= 1'b0;
                paddr   <= 12'b0;
                pwdata  <= 32'b0;
                count_trace_lines(line_count);
                if (line_count == 0) begin
                        $display("The trace file %s is empty", TRACE_FILE);
                        stop_with_failure();
                end
                repeat (RESET_CYCLES) @(posedge pclk);
                rst_n <= 1'b1;
                sweep_reset_registers();
                run_trace();
                $display("*** PASSED ***");
                $finish;
        end

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top (
        input  wire         pclk_i,
        input  wire         rst_n_i,
        input  wire         psel_i,
        input  wire         penable_i,
        input  wire         pwrite_i,
        input  wire  [11:0] paddr_i,
        input  wire  [31:0] pwdata_i,
        output logic [31:0] prdata_o,
        output logic        pready_o,
        output logic        pslverr_o
);

        // Decoder to queue.
        logic                         push;
        logic [core_pkg::ALU_W-1:0]   dec_alu_op;
        logic [core_pkg::REG_AW-1:0]  dec_rs_addr;
        logic [core_pkg::REG_AW-1:0]  dec_rt_addr;
        logic                         dec_num2_need;
        logic [31:0]                  dec_imm_value;
        logic [core_pkg::REG_AW-1:0]  dec_wr_addr;
        logic                         full;
        logic [core_pkg::QUEUE_AW:0]  count;

        // Queue to execute unit.
        logic                         valid;
        logic                         pop;
        logic [core_pkg::ALU_W-1:0]   head_alu_op;
        logic [core_pkg::REG_AW-1:0]  head_rs_addr;
        logic [core_pkg::REG_AW-1:0]  head_rt_addr;
        logic                         head_num2_need;
        logic [31:0]                  head_imm_value;
        logic [core_pkg::REG_AW-1:0]  head_wr_addr;

        logic                         run;
        logic [core_pkg::REG_AW-1:0]  dbg_addr;
        logic [31:0]                  dbg_data;

        dispatch_decoder u_decoder (
                .pclk_i        (pclk_i),
                .rst_n_i       (rst_n_i),
                .psel_i        (psel_i),
                .penable_i     (penable_i),
                .pwrite_i      (pwrite_i),
                .paddr_i       (paddr_i),
                .pwdata_i      (pwdata_i),
                .queue_full_i  (full),
                .queue_count_i (count),
                .queue_valid_i (valid),
                .dbg_data_i    (dbg_data),
                .prdata_o      (prdata_o),
                .pready_o      (pready_o),
                .pslverr_o     (pslverr_o),
                .push_o        (push),
                .alu_op_o      (dec_alu_op),
                .rs_addr_o     (dec_rs_addr),
                .rt_addr_o     (dec_rt_addr),
                .num2_need_o   (dec_num2_need),
                .imm_value_o   (dec_imm_value),
                .wr_addr_o     (dec_wr_addr),
                .run_o         (run),
                .dbg_addr_o    (dbg_addr)
        );

        issue_queue u_queue (
                .pclk_i      (pclk_i),
                .rst_n_i     (rst_n_i),
                .push_i      (push),
                .alu_op_i    (dec_alu_op),
                .rs_addr_i   (dec_rs_addr),
                .rt_addr_i   (dec_rt_addr),
                .num2_need_i (dec_num2_need),
                .imm_value_i (dec_imm_value),
                .wr_addr_i   (dec_wr_addr),
                .pop_i       (pop),
                .full_o      (full),
                .count_o     (count),
                .valid_o     (valid),
                .alu_op_o    (head_alu_op),
                .rs_addr_o   (head_rs_addr),
                .rt_addr_o   (head_rt_addr),
                .num2_need_o (head_num2_need),
                .imm_value_o (head_imm_value),
                .wr_addr_o   (head_wr_addr)
        );

        execute_unit u_execute (
                .pclk_i      (pclk_i),
                .rst_n_i     (rst_n_i),
                .run_i       (run),
                .valid_i     (valid),
                .alu_op_i    (head_alu_op),
                .rs_addr_i   (head_rs_addr),
                .rt_addr_i   (head_rt_addr),
                .num2_need_i (head_num2_need),
                .imm_value_i (head_imm_value),
                .wr_addr_i   (head_wr_addr),
                .dbg_addr_i  (dbg_addr),
                .pop_o       (pop),
                .dbg_data_o  (dbg_data)
        );

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
        input  wire                            pclk_i,
        input  wire                            rst_n_i,
        input  wire                            run_i,
        input  wire                            valid_i,
        input  wire  [core_pkg::ALU_W-1:0]     alu_op_i,
        input  wire  [core_pkg::REG_AW-1:0]    rs_addr_i,
        input  wire  [core_pkg::REG_AW-1:0]    rt_addr_i,
        input  wire                            num2_need_i,
        input  wire  [31:0]                    imm_value_i,
        input  wire  [core_pkg::REG_AW-1:0]    wr_addr_i,
        input  wire  [core_pkg::REG_AW-1:0]    dbg_addr_i,
        output logic                           pop_o,
        output logic [31:0]                    dbg_data_o
);

        logic [31:0] regs [core_pkg::REG_COUNT];
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] result;

        // One element per cycle while running.
        assign pop_o = valid_i & run_i;

        assign op1 = regs[rs_addr_i];
        assign op2 = num2_need_i ? regs[rt_addr_i] : imm_value_i;

        always_comb begin
                case (alu_op_i)
                        core_pkg::ALU_OR:  result = op1 | op2;
                        core_pkg::ALU_ADD: result = op1 + op2;
                        core_pkg::ALU_SUB: result = op1 - op2;
                        core_pkg::ALU_AND: result = op1 & op2;
                        core_pkg::ALU_LUI: result = op2; // Immediate already shifted.
                        default:           result = 32'b0;
                endcase
        end

        // Entry 0 is never written, so r0 stays zero.
        always_ff @(posedge pclk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        for (int i = 0; i < core_pkg::REG_COUNT; i++)
                                regs[i] <= 32'b0;
                end else if (pop_o && wr_addr_i != '0) begin
                        regs[wr_addr_i] <= result;
                end
        end

        assign dbg_data_o = regs[dbg_addr_i]; // Host read port.

endmodule

`default_nettype wire

//--- source/issue_queue.sv
`timescale 1ns/10ps
`default_nettype none

module issue_queue (
        input  wire                            pclk_i,
        input  wire                            rst_n_i,
        input  wire                            push_i,
        input  wire  [core_pkg::ALU_W-1:0]     alu_op_i,
        input  wire  [core_pkg::REG_AW-1:0]    rs_addr_i,
        input  wire  [core_pkg::REG_AW-1:0]    rt_addr_i,
        input  wire                            num2_need_i,
        input  wire  [31:0]                    imm_value_i,
        input  wire  [core_pkg::REG_AW-1:0]    wr_addr_i,
        input  wire                            pop_i,
        output logic                           full_o,
        output logic [core_pkg::QUEUE_AW:0]    count_o,
        output logic                           valid_o,
        output logic [core_pkg::ALU_W-1:0]     alu_op_o,
        output logic [core_pkg::REG_AW-1:0]    rs_addr_o,
        output logic [core_pkg::REG_AW-1:0]    rt_addr_o,
        output logic                           num2_need_o,
        output logic [31:0]                    imm_value_o,
        output logic [core_pkg::REG_AW-1:0]    wr_addr_o
);

        logic [core_pkg::ALU_W-1:0]  alu_op_mem    [core_pkg::QUEUE_DEPTH];
        logic [core_pkg::REG_AW-1:0] rs_addr_mem   [core_pkg::QUEUE_DEPTH];
        logic [core_pkg::REG_AW-1:0] rt_addr_mem   [core_pkg::QUEUE_DEPTH];
        logic                        num2_need_mem [core_pkg::QUEUE_DEPTH];
        logic [31:0]                 imm_value_mem [core_pkg::QUEUE_DEPTH];
        logic [core_pkg::REG_AW-1:0] wr_addr_mem   [core_pkg::QUEUE_DEPTH];

        logic [core_pkg::QUEUE_AW-1:0] wr_ptr;
        logic [core_pkg::QUEUE_AW-1:0] rd_ptr;
        logic [core_pkg::QUEUE_AW:0]   count;
        logic                          do_push;
        logic                          do_pop;

        assign full_o  = count == core_pkg::QUEUE_DEPTH;
        assign valid_o = count != '0;
        assign count_o = count;
        assign do_push = push_i & ~full_o;
        assign do_pop  = pop_i & valid_o;

        always_ff @(posedge pclk_i) begin
                if (do_push) begin
                        alu_op_mem[wr_ptr]    <= alu_op_i;
                        rs_addr_mem[wr_ptr]   <= rs_addr_i;
                        rt_addr_mem[wr_ptr]   <= rt_addr_i;
                        num2_need_mem[wr_ptr] <= num2_need_i;
                        imm_value_mem[wr_ptr] <= imm_value_i;
                        wr_addr_mem[wr_ptr]   <= wr_addr_i;
                end
        end

        // Pointers wrap on their own.
        always_ff @(posedge pclk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= rd_ptr + 1'b1;
                        if (do_push && !do_pop)
                                count <= count + 1'b1;
                        else if (do_pop && !do_push)
                                count <= count - 1'b1;
                end
        end

        // Head element.
        assign alu_op_o    = alu_op_mem[rd_ptr];
        assign rs_addr_o   = rs_addr_mem[rd_ptr];
        assign rt_addr_o   = rt_addr_mem[rd_ptr];
        assign num2_need_o = num2_need_mem[rd_ptr];
        assign imm_value_o = imm_value_mem[rd_ptr];
        assign wr_addr_o   = wr_addr_mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/dispatch_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_decoder (
        input  wire                            pclk_i,
        input  wire                            rst_n_i,
        input  wire                            psel_i,
        input  wire                            penable_i,
        input  wire                            pwrite_i,
        input  wire  [11:0]                    paddr_i,
        input  wire  [31:0]                    pwdata_i,
        input  wire                            queue_full_i,
        input  wire  [core_pkg::QUEUE_AW:0]    queue_count_i,
        input  wire                            queue_valid_i,
        input  wire  [31:0]                    dbg_data_i,
        output logic [31:0]                    prdata_o,
        output logic                           pready_o,
        output logic                           pslverr_o,
        output logic                           push_o,
        output logic [core_pkg::ALU_W-1:0]     alu_op_o,
        output logic [core_pkg::REG_AW-1:0]    rs_addr_o,
        output logic [core_pkg::REG_AW-1:0]    rt_addr_o,
        output logic                           num2_need_o,
        output logic [31:0]                    imm_value_o,
        output logic [core_pkg::REG_AW-1:0]    wr_addr_o,
        output logic                           run_o,
        output logic [core_pkg::REG_AW-1:0]    dbg_addr_o
);

        logic           access;
        logic           hit_inst;
        logic           hit_status;
        logic           hit_ctrl;
        logic           hit_reg;
        logic           run_q;
        isa_pkg::inst_u inst;
        logic [31:0]    imm_sext;
        logic [31:0]    imm_zext;

        assign access     = psel_i & penable_i;
        assign hit_inst   = paddr_i == core_pkg::ADDR_INST;
        assign hit_status = paddr_i == core_pkg::ADDR_STATUS;
        assign hit_ctrl   = paddr_i == core_pkg::ADDR_CTRL;
        assign hit_reg    = (paddr_i[11:7] == core_pkg::ADDR_REG_BASE[11:7]) &&
                            (paddr_i[1:0] == 2'b00);

        assign pready_o   = access; // No wait states.
        assign push_o     = access & pwrite_i & hit_inst & ~queue_full_i;
        assign run_o      = run_q;
        assign dbg_addr_o = paddr_i[6:2];

        // Full queue on push, and anything read only or unmapped, is refused.
        always_comb begin
                pslverr_o = 1'b0;
                if (access) begin
                        if (pwrite_i)
                                pslverr_o = hit_inst ? queue_full_i : !hit_ctrl;
                        else
                                pslverr_o = !(hit_inst | hit_status | hit_ctrl | hit_reg);
                end
        end

        always_comb begin
                prdata_o = 32'b0;
                if (hit_status)
                        prdata_o = {23'b0, queue_valid_i, 5'b0, queue_count_i};
                else if (hit_ctrl)
                        prdata_o = {31'b0, run_q};
                else if (hit_reg)
                        prdata_o = dbg_data_i;
        end

        always_ff @(posedge pclk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        run_q <= 1'b1;
                end else if (access && pwrite_i && hit_ctrl) begin
                        run_q <= pwdata_i[0];
                end
        end

        assign inst     = pwdata_i;
        assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};
        assign imm_zext = {16'b0, inst.i.imm};

        always_comb begin
                // Unknown opcodes: rt = rs | sign-extended imm.
                alu_op_o    = core_pkg::ALU_OR;
                rs_addr_o   = inst.i.rs;
                rt_addr_o   = inst.i.rt;
                num2_need_o = 1'b0;
                imm_value_o = imm_sext;
                wr_addr_o   = inst.i.rt;
                case (inst.i.op)
                        isa_pkg::OP_ORI: begin
                                imm_value_o = imm_zext;
                        end
                        isa_pkg::OP_ADDIU: begin
                                alu_op_o = core_pkg::ALU_ADD;
                        end
                        isa_pkg::OP_ANDI: begin
                                alu_op_o    = core_pkg::ALU_AND;
                                imm_value_o = imm_zext;
                        end
                        isa_pkg::OP_LUI: begin
                                alu_op_o    = core_pkg::ALU_LUI;
                                imm_value_o = {inst.i.imm, 16'b0};
                        end
                        isa_pkg::OP_SPECIAL: begin
                                num2_need_o = 1'b1;
                                wr_addr_o   = inst.r.rd;
                                case (inst.r.funct)
                                        isa_pkg::FN_ADDU: alu_op_o = core_pkg::ALU_ADD;
                                        isa_pkg::FN_SUBU: alu_op_o = core_pkg::ALU_SUB;
                                        isa_pkg::FN_AND:  alu_op_o = core_pkg::ALU_AND;
                                        isa_pkg::FN_OR:   alu_op_o = core_pkg::ALU_OR;
                                        default:          alu_op_o = core_pkg::ALU_OR;
                                endcase
                        end
                        default: begin
                        end
                endcase
        end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

        // Register file.
        localparam int REG_COUNT = 32;
        localparam int REG_AW    = 5;

        // Issue queue, depth must stay a power of two.
        localparam int QUEUE_DEPTH = 4;
        localparam int QUEUE_AW    = 2;

        // ALU operation codes carried in each queue element.
        localparam int ALU_W = 3;

        localparam logic [ALU_W-1:0] ALU_OR  = 3'd0;
        localparam logic [ALU_W-1:0] ALU_ADD = 3'd1;
        localparam logic [ALU_W-1:0] ALU_SUB = 3'd2;
        localparam logic [ALU_W-1:0] ALU_AND = 3'd3;
        localparam logic [ALU_W-1:0] ALU_LUI = 3'd4; // Passes operand 2.

        // APB word addresses.
        localparam logic [11:0] ADDR_INST     = 12'h000; // Write only.
        localparam logic [11:0] ADDR_STATUS   = 12'h004;
        localparam logic [11:0] ADDR_CTRL     = 12'h008;
        localparam logic [11:0] ADDR_REG_BASE = 12'h100; // Plus 4n, read only.

endpackage

`default_nettype wire

//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

        // Primary opcodes, bits 31:26.
        localparam logic [5:0] OP_SPECIAL = 6'b000000;
        localparam logic [5:0] OP_ADDIU   = 6'b001001;
        localparam logic [5:0] OP_ANDI    = 6'b001100;
        localparam logic [5:0] OP_ORI     = 6'b001101;
        localparam logic [5:0] OP_LUI     = 6'b001111;

        // Function field of SPECIAL, bits 5:0.
        localparam logic [5:0] FN_ADDU = 6'b100001;
        localparam logic [5:0] FN_SUBU = 6'b100011;
        localparam logic [5:0] FN_AND  = 6'b100100;
        localparam logic [5:0] FN_OR   = 6'b100101;

        // One instruction word, seen as I-type or R-type.
        typedef union packed {
                struct packed {
                        logic [5:0]  op;
                        logic [4:0]  rs;
                        logic [4:0]  rt;
                        logic [15:0] imm;
                } i;
                struct packed {
                        logic [5:0] op;
                        logic [4:0] rs;
                        logic [4:0] rt;
                        logic [4:0] rd;
                        logic [4:0] shamt; // Unused by this subset.
                        logic [5:0] funct;
                } r;
        } inst_u;

endpackage

`default_nettype wire
